//--- src/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  regIdx_t;   // 15 is the pc, 0 reads zero
    typedef logic [3:0]  opcode_t;
    typedef logic [1:0]  insnKind_t;
    typedef logic [9:0]  memAddr_t;

    localparam int    MEM_WORDS    = 1024;
    localparam word_t RESET_VECTOR = 32'h0000_0000;
    localparam int    EXEC_LATENCY = 4;   // en to done

    // operand routing per kind
    localparam insnKind_t KIND_XYI  = 2'd0;
    localparam insnKind_t KIND_XIY  = 2'd1;
    localparam insnKind_t KIND_IXY  = 2'd2;
    localparam insnKind_t KIND_WIDE = 2'd3;   // 20-bit immediate form

    localparam opcode_t OP_OR   = 4'h0;
    localparam opcode_t OP_AND  = 4'h1;
    localparam opcode_t OP_XOR  = 4'h2;
    localparam opcode_t OP_SRA  = 4'h3;
    localparam opcode_t OP_ADD  = 4'h4;
    localparam opcode_t OP_MUL  = 4'h5;
    localparam opcode_t OP_EQ   = 4'h6;
    localparam opcode_t OP_LT   = 4'h7;   // signed
    localparam opcode_t OP_ORN  = 4'h8;
    localparam opcode_t OP_ANDN = 4'h9;
    localparam opcode_t OP_PACK = 4'ha;
    localparam opcode_t OP_SRL  = 4'hb;
    localparam opcode_t OP_SUB  = 4'hc;
    localparam opcode_t OP_SLL  = 4'hd;
    localparam opcode_t OP_BIT  = 4'he;
    localparam opcode_t OP_GE   = 4'hf;   // signed

    typedef enum logic [2:0] {
        EXECUTE,
        AWAIT_EXEC,
        DATA_ACCESS,
        DATA_LATCH,
        UPDATE_PC,
        FETCH,
        LATCH_INSN
    } coreState_t;

endpackage

//--- src/regFile.sv
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    writeEn_i,
    input  regIdx_t writeIdx_i,
    input  regIdx_t readX_i,
    input  regIdx_t readY_i,
    input  word_t   writeData_i,
    input  word_t   pcPlusOne_i,
    input  regIdx_t readZ_i,
    output word_t   valX_o,
    output word_t   valY_o,
    output word_t   valZ_o
);

    word_t regs    [1:14];
    word_t regView [0:15];   // what the read ports see

    always_comb begin
        regView[0] = '0;
        for (int i = 1; i < 15; i++) begin
            regView[i] = regs[i];
        end
        regView[15] = pcPlusOne_i;   // pc reads as next address
    end

    assign valX_o = regView[readX_i];
    assign valY_o = regView[readY_i];
    assign valZ_o = regView[readZ_i];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 1; i < 15; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn_i && writeIdx_i != 4'd0 && writeIdx_i != 4'd15) begin
            regs[writeIdx_i] <= writeData_i;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
        writeEn_i |-> !$isunknown(writeIdx_i));

endmodule

//--- src/insnDecoder.sv
`timescale 1ns/100ps

module insnDecoder import cpuPkg::*; (
    input  word_t   insn_i,
    input  word_t   valX_i,
    input  word_t   valY_i,
    output regIdx_t idxZ_o,
    output regIdx_t idxX_o,
    output regIdx_t idxY_o,
    output opcode_t op_o,
    output word_t   valA_o,
    output word_t   valB_o,
    output word_t   valC_o,
    output logic    storing_o,
    output logic    loading_o,
    output logic    derefRhs_o,
    output logic    branching_o
);

    insnKind_t  kind;
    logic [1:0] mode;
    word_t      valI;

    assign kind   = insn_i[31:30];
    assign mode   = insn_i[29:28];
    assign idxZ_o = insn_i[27:24];
    assign idxX_o = insn_i[23:20];

    always_comb begin
        if (kind == KIND_WIDE) begin
            idxY_o = '0;
            op_o   = OP_OR;
            valI   = {{12{insn_i[19]}}, insn_i[19:0]};
        end else begin
            idxY_o = insn_i[19:16];
            op_o   = insn_i[15:12];
            valI   = {{20{insn_i[11]}}, insn_i[11:0]};
        end
    end

    always_comb begin
        case (kind)
            KIND_XYI: begin
                valA_o = valX_i;
                valB_o = valY_i;
                valC_o = valI;
            end
            KIND_XIY: begin
                valA_o = valX_i;
                valB_o = valI;
                valC_o = valY_i;
            end
            KIND_IXY: begin
                valA_o = valI;
                valB_o = valX_i;
                valC_o = valY_i;
            end
            default: begin   // wide immediate, A forced to zero
                valA_o = '0;
                valB_o = valX_i;
                valC_o = valI;
            end
        endcase
    end

    assign storing_o   = ^mode;   // modes 1 and 2
    assign loading_o   = &mode;
    assign derefRhs_o  = mode[0];   // result is the memory address
    assign branching_o = (&idxZ_o) & ~storing_o;

endmodule

//--- src/execUnit.sv
`timescale 1ns/100ps

module execUnit import cpuPkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    en_i,
    input  opcode_t op_i,
    input  word_t   valA_i,
    input  word_t   valB_i,
    input  word_t   valC_i,
    output logic    done_o,
    output word_t   result_o
);

    logic [EXEC_LATENCY-1:0] validPipe;
    opcode_t opS1;
    word_t   aS1, bS1, cS1;
    word_t   yS2, cS2;
    word_t   zS3;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[EXEC_LATENCY-2:0], en_i};
        end
    end

    assign done_o = validPipe[EXEC_LATENCY-1];

    always_ff @(posedge clk) begin
        opS1 <= op_i;   // stage 1 operands
        aS1  <= valA_i;
        bS1  <= valB_i;
        cS1  <= valC_i;

        case (opS1)
            OP_OR:   yS2 <= aS1 | bS1;
            OP_AND:  yS2 <= aS1 & bS1;
            OP_XOR:  yS2 <= aS1 ^ bS1;
            OP_SRA:  yS2 <= $signed(aS1) >>> bS1;
            OP_ADD:  yS2 <= aS1 + bS1;
            OP_MUL:  yS2 <= aS1 * bS1;   // low word
            OP_EQ:   yS2 <= {32{aS1 == bS1}};
            OP_LT:   yS2 <= {32{$signed(aS1) < $signed(bS1)}};
            OP_ORN:  yS2 <= aS1 | ~bS1;
            OP_ANDN: yS2 <= aS1 & ~bS1;
            OP_PACK: yS2 <= {aS1[19:0], bS1[11:0]};
            OP_SRL:  yS2 <= aS1 >> bS1;
            OP_SUB:  yS2 <= aS1 - bS1;
            OP_SLL:  yS2 <= aS1 << bS1;
            OP_BIT:  yS2 <= {32{|(aS1 & (word_t'(1) << bS1))}};
            default: yS2 <= {32{$signed(aS1) >= $signed(bS1)}};
        endcase
        cS2 <= cS1;

        zS3      <= yS2 + cS2;   // stage 3 adds C
        result_o <= zS3;
    end

endmodule

//--- src/coreControl.sv
`timescale 1ns/100ps

module coreControl import cpuPkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    output word_t adrI_o,
    output logic  stbI_o,
    output logic  cycI_o,
    input  word_t datI_i,
    input  logic  ackI_i,
    input  logic  errI_i,
    output word_t adrD_o,
    output word_t datD_o,
    output logic  wenD_o,
    output logic  stbD_o,
    output logic  cycD_o,
    input  word_t datD_i,
    input  logic  ackD_i,
    input  logic  errD_i,
    output logic  halt_o
);

    coreState_t state;
    word_t      insn;
    word_t      fetchAddr;
    word_t      nextPc;
    word_t      execResult;
    word_t      loadData;
    word_t      nextZ;

    regIdx_t idxZ, idxX, idxY;
    opcode_t op;
    word_t   valX, valY, valZ;
    word_t   valA, valB, valC;
    word_t   result;
    logic    storing, loading, derefRhs, branching;
    logic    execEn, execDone, memAccess, writeEn;

    insnDecoder decoder (
        .insn_i(insn), .valX_i(valX), .valY_i(valY),
        .idxZ_o(idxZ), .idxX_o(idxX), .idxY_o(idxY), .op_o(op),
        .valA_o(valA), .valB_o(valB), .valC_o(valC),
        .storing_o(storing), .loading_o(loading),
        .derefRhs_o(derefRhs), .branching_o(branching)
    );

    execUnit exec (
        .clk(clk), .reset_n(reset_n), .en_i(execEn), .op_i(op),
        .valA_i(valA), .valB_i(valB), .valC_i(valC),
        .done_o(execDone), .result_o(result)
    );

    regFile regs (
        .clk(clk), .reset_n(reset_n), .writeEn_i(writeEn), .writeIdx_i(idxZ),
        .readX_i(idxX), .readY_i(idxY), .writeData_i(nextZ),
        .pcPlusOne_i(nextPc), .readZ_i(idxZ),
        .valX_o(valX), .valY_o(valY), .valZ_o(valZ)
    );

    assign memAccess = loading | storing;
    assign execEn    = (state == EXECUTE) && !halt_o;
    assign writeEn   = (state == UPDATE_PC) && !storing && !halt_o;
    assign nextZ     = derefRhs ? loadData : execResult;

    assign stbI_o = (state == FETCH) && !halt_o;
    assign cycI_o = stbI_o;
    assign adrI_o = fetchAddr;

    assign stbD_o = (state == DATA_ACCESS) && memAccess && !halt_o;
    assign cycD_o = stbD_o;
    assign wenD_o = stbD_o && storing;
    assign adrD_o = derefRhs ? execResult : valZ;   // mode picks address vs data
    assign datD_o = derefRhs ? valZ : execResult;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= FETCH;
            fetchAddr <= RESET_VECTOR;
            halt_o    <= 1'b0;
        end else begin
            if (errI_i || errD_i) begin
                halt_o <= 1'b1;   // sticky until reset
            end
            if (!halt_o) begin
                case (state)
                    EXECUTE:     state <= AWAIT_EXEC;
                    AWAIT_EXEC:  if (execDone) state <= DATA_ACCESS;
                    DATA_ACCESS: if (!memAccess || ackD_i) state <= DATA_LATCH;
                    DATA_LATCH:  state <= UPDATE_PC;
                    UPDATE_PC: begin
                        state     <= FETCH;
                        fetchAddr <= branching ? nextZ : nextPc;
                    end
                    FETCH:       if (ackI_i) state <= LATCH_INSN;
                    default:     state <= EXECUTE;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && ackI_i) begin
            nextPc <= fetchAddr + 32'd1;
        end
        if (state == LATCH_INSN) begin
            insn <= datI_i;   // memory holds read data
        end
        if (state == AWAIT_EXEC && execDone) begin
            execResult <= result;
        end
        if (state == DATA_LATCH) begin
            loadData <= datD_i;
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) !(stbD_o && stbI_o));

endmodule

//--- src/localMemory.sv
`timescale 1ns/100ps

module localMemory import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  word_t    adrI_i,
    input  logic     stbI_i,
    input  logic     cycI_i,
    output word_t    datI_o,
    output logic     ackI_o,
    output logic     errI_o,
    input  word_t    adrD_i,
    input  word_t    datD_i,
    input  logic     wenD_i,
    input  logic     stbD_i,
    input  logic     cycD_i,
    output word_t    datD_o,
    output logic     ackD_o,
    output logic     errD_o,
    input  logic     loadEn_i,
    input  logic     loadWe_i,
    input  memAddr_t loadAddr_i,
    input  word_t    loadData_i,
    output word_t    loadData_o
);

    word_t mem [MEM_WORDS];
    logic  startI, startD;
    logic  inRangeI, inRangeD;

    // new request, not yet answered; loader wins
    assign startI   = cycI_i && stbI_i && !ackI_o && !errI_o && !loadEn_i;
    assign startD   = cycD_i && stbD_i && !ackD_o && !errD_o && !loadEn_i;
    assign inRangeI = adrI_i < MEM_WORDS;
    assign inRangeD = adrD_i < MEM_WORDS;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            ackI_o <= 1'b0;
            errI_o <= 1'b0;
            ackD_o <= 1'b0;
            errD_o <= 1'b0;
        end else begin
            ackI_o <= startI && inRangeI;
            errI_o <= startI && !inRangeI;
            ackD_o <= startD && inRangeD;
            errD_o <= startD && !inRangeD;
        end
    end

    always_ff @(posedge clk) begin
        if (loadEn_i) begin
            if (loadWe_i) mem[loadAddr_i] <= loadData_i;
            loadData_o <= mem[loadAddr_i];
        end
        if (startI && inRangeI) datI_o <= mem[memAddr_t'(adrI_i)];
        if (startD && inRangeD) begin
            if (wenD_i) mem[memAddr_t'(adrD_i)] <= datD_i;   // lands with the ack
            else datD_o <= mem[memAddr_t'(adrD_i)];
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) ackI_o |-> $past(stbI_i));
    assert property (@(posedge clk) disable iff (!reset_n) ackD_o |-> $past(stbD_i));

endmodule

//--- src/cpuTop.sv
`timescale 1ns/100ps

module cpuTop import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     loadEn_i,
    input  logic     loadWe_i,
    input  memAddr_t loadAddr_i,
    input  word_t    loadData_i,
    output word_t    loadData_o,
    output logic     halt_o
);

    word_t adrI, datI;
    logic  stbI, cycI, ackI, errI;
    word_t adrD, datDToMem, datDFromMem;
    logic  wenD, stbD, cycD, ackD, errD;

    coreControl core (
        .clk(clk), .reset_n(reset_n),
        .adrI_o(adrI), .stbI_o(stbI), .cycI_o(cycI),
        .datI_i(datI), .ackI_i(ackI), .errI_i(errI),
        .adrD_o(adrD), .datD_o(datDToMem), .wenD_o(wenD),
        .stbD_o(stbD), .cycD_o(cycD),
        .datD_i(datDFromMem), .ackD_i(ackD), .errD_i(errD),
        .halt_o(halt_o)
    );

    localMemory memory (
        .clk(clk), .reset_n(reset_n),
        .adrI_i(adrI), .stbI_i(stbI), .cycI_i(cycI),
        .datI_o(datI), .ackI_o(ackI), .errI_o(errI),
        .adrD_i(adrD), .datD_i(datDToMem), .wenD_i(wenD),
        .stbD_i(stbD), .cycD_i(cycD),
        .datD_o(datDFromMem), .ackD_o(ackD), .errD_o(errD),
        .loadEn_i(loadEn_i), .loadWe_i(loadWe_i), .loadAddr_i(loadAddr_i),
        .loadData_i(loadData_i), .loadData_o(loadData_o)
    );

endmodule

//--- dv/cpuPrograms.svh
    task automatic buildTable();
        word_t   a, c, b1, b2;
        word_t   aExt, cExt, b1Ext, b2Ext;
        opcode_t opc;
        logic    shiftLike;
        rowCount = 0;

        startRow("first fetch from reset vector", 10'd140);
        addInsn(encodeWide(2'd1, 4'd15, 4'd0, 20'd140));   // mem[140] = pc read
        expectWord(0, RESET_VECTOR + 32'd1);

        for (int op = 0; op < 16; op++) begin
            opc       = opcode_t'(op);
            shiftLike = opc inside {OP_SRA, OP_SRL, OP_SLL, OP_BIT};
            a         = randomBits(20);
            c         = randomBits(20);
            b1        = shiftLike ? randomBits(5) : randomBits(12);   // keep shifts below 32
            b2        = shiftLike ? randomBits(5) : randomBits(12);
            if (opc == OP_EQ) begin
                a = {{20{b1[11]}}, b1[11:0]};   // equal first pair
            end
            aExt      = {{12{a[19]}}, a[19:0]};
            cExt      = {{12{c[19]}}, c[19:0]};
            b1Ext     = {{20{b1[11]}}, b1[11:0]};
            b2Ext     = {{20{b2[11]}}, b2[11:0]};
            startRow($sformatf("opcode %h", opc), 10'd150);
            addInsn(encodeWide(2'd0, 4'd1, 4'd0, a[19:0]));
            addInsn(encodeWide(2'd0, 4'd2, 4'd0, c[19:0]));
            addInsn(encodeWide(2'd0, 4'd3, 4'd0, 20'd150));
            addInsn(encodeWide(2'd0, 4'd4, 4'd0, 20'd151));
            addInsn(encodeInsn(KIND_XIY, 2'd2, 4'd3, 4'd1, 4'd2, opc, b1[11:0]));
            addInsn(encodeInsn(KIND_XIY, 2'd2, 4'd4, 4'd2, 4'd1, opc, b2[11:0]));
            expectWord(0, refOp(opc, aExt, b1Ext) + cExt);
            expectWord(1, refOp(opc, cExt, b2Ext) + aExt);
        end

        startRow("operand routing by kind", 10'd100);
        addInsn(encodeWide(2'd0, 4'd1, 4'd0, 20'd7000));   // X
        addInsn(encodeWide(2'd0, 4'd2, 4'd0, 20'd300));   // Y
        for (int i = 0; i < 4; i++) begin
            addInsn(encodeWide(2'd0, regIdx_t'(3 + i), 4'd0, 20'(100 + i)));
        end
        addInsn(encodeInsn(KIND_XYI, 2'd2, 4'd3, 4'd1, 4'd2, OP_SUB, 12'hffb));   // imm -5
        addInsn(encodeInsn(KIND_XIY, 2'd2, 4'd4, 4'd1, 4'd2, OP_SUB, 12'hffb));
        addInsn(encodeInsn(KIND_IXY, 2'd2, 4'd5, 4'd1, 4'd2, OP_SUB, 12'hffb));
        addInsn(encodeWide(2'd2, 4'd6, 4'd1, 20'hedcbb));   // imm -74565
        expectWord(0, 32'd7000 - 32'd300 - 32'd5);
        expectWord(1, 32'd7000 + 32'd5 + 32'd300);
        expectWord(2, 32'd300 - 32'd5 - 32'd7000);
        expectWord(3, 32'd7000 - 32'd74565);

        startRow("loads and stores", 10'd110);
        addInsn(encodeWide(2'd0, 4'd1, 4'd0, 20'd110));
        addInsn(encodeWide(2'd0, 4'd2, 4'd0, 20'h01234));
        addInsn(encodeWide(2'd3, 4'd3, 4'd1, 20'd0));   // r3 = mem[110]
        addInsn(encodeWide(2'd1, 4'd3, 4'd1, 20'd1));   // mem[111] = r3
        addInsn(encodeWide(2'd0, 4'd4, 4'd1, 20'd2));
        addInsn(encodeWide(2'd2, 4'd4, 4'd2, 20'd5));   // mem[r4] = r2 + 5
        addInsn(encodeInsn(KIND_XIY, 2'd0, 4'd5, 4'd3, 4'd2, OP_ADD, 12'd1));
        addInsn(encodeWide(2'd1, 4'd5, 4'd1, 20'd3));
        expectWord(1, fillPattern(10'd110));
        expectWord(2, 32'h0000_1239);
        expectWord(3, fillPattern(10'd110) + 32'h0000_1235);

        startRow("branches through r15", 10'd120);
        addInsn(encodeWide(2'd0, 4'd1, 4'd0, 20'd120));
        addInsn(encodeWide(2'd0, 4'd15, 4'd0, 20'd4));   // jump to word 4
        addInsn(encodeWide(2'd1, 4'd1, 4'd1, 20'd0));   // marker, skipped
        addInsn(encodeWide(2'd1, 4'd1, 4'd1, 20'd1));
        addInsn(encodeInsn(KIND_XYI, 2'd0, 4'd2, 4'd15, 4'd0, OP_OR, 12'd0));
        addInsn(encodeWide(2'd1, 4'd2, 4'd1, 20'd2));
        addInsn(encodeInsn(KIND_XIY, 2'd0, 4'd15, 4'd15, 4'd0, OP_ADD, 12'd1));   // over word 7
        addInsn(encodeWide(2'd1, 4'd1, 4'd1, 20'd3));
        expectWord(2, 32'd5);   // word 4 sees its successor

        startRow("halt on bus error", 10'd130);
        addInsn(encodeWide(2'd0, 4'd1, 4'd0, 20'd130));
        addInsn(encodeWide(2'd1, 4'd1, 4'd1, 20'd0));
        addInsn(encodeWide(2'd3, 4'd2, 4'd0, 20'd4095));   // load out of range
        addInsn(encodeWide(2'd1, 4'd1, 4'd1, 20'd1));   // never lands
        expectWord(0, 32'd130);
    endtask

//--- dv/cpuTb.sv
`timescale 1ns/100ps

module cpuTb import cpuPkg::*; ();

    localparam int PROG_WORDS  = 12;
    localparam int CHECK_WORDS = 4;
    localparam int MAX_ROWS    = 24;
    localparam int RUN_TIMEOUT = 2000;   // cycles until halt_o

    logic     clk;
    logic     reset_n;
    logic     loadEn;
    logic     loadWe;
    memAddr_t loadAddr;
    word_t    loadDataIn;
    word_t    loadDataOut;
    logic     halt;

    word_t    progMem [MAX_ROWS][PROG_WORDS];
    memAddr_t chkBase [MAX_ROWS];   // four words checked from here
    word_t    expWord [MAX_ROWS][CHECK_WORDS];
    logic     expHalt [MAX_ROWS];
    string    rowName [MAX_ROWS];
    int       rowCount;
    int       rowLen;
    word_t    lfsrState = 32'h44a9;
    int       errors;
    int       passCount;
    int       failCount;

    cpuTop i_dut (
        .clk(clk), .reset_n(reset_n),
        .loadEn_i(loadEn), .loadWe_i(loadWe), .loadAddr_i(loadAddr),
        .loadData_i(loadDataIn), .loadData_o(loadDataOut),
        .halt_o(halt)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    function automatic word_t lfsrStep(word_t s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic word_t randomBits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic word_t fillPattern(memAddr_t a);
        return {16'hfeed, 6'h00, a};
    endfunction

    function automatic word_t encodeInsn(insnKind_t kind, logic [1:0] mode, regIdx_t z,
                                         regIdx_t x, regIdx_t y, opcode_t op,
                                         logic [11:0] imm);
        return {kind, mode, z, x, y, op, imm};
    endfunction

    function automatic word_t encodeWide(logic [1:0] mode, regIdx_t z, regIdx_t x,
                                         logic [19:0] imm);
        return {KIND_WIDE, mode, z, x, imm};
    endfunction

    // expected A op B for the sixteen operations
    function automatic word_t refOp(opcode_t op, word_t a, word_t b);
        case (op)
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_XOR:  return a ^ b;
            OP_SRA:  return $signed(a) >>> b[4:0];
            OP_ADD:  return a + b;
            OP_MUL:  return a * b;
            OP_EQ:   return (a == b) ? 32'hffff_ffff : 32'h0;
            OP_LT:   return ($signed(a) < $signed(b)) ? 32'hffff_ffff : 32'h0;
            OP_ORN:  return a | ~b;
            OP_ANDN: return a & ~b;
            OP_PACK: return {a[19:0], b[11:0]};
            OP_SRL:  return a >> b[4:0];
            OP_SUB:  return a - b;
            OP_SLL:  return a << b[4:0];
            OP_BIT:  return a[b[4:0]] ? 32'hffff_ffff : 32'h0;
            default: return ($signed(a) >= $signed(b)) ? 32'hffff_ffff : 32'h0;
        endcase
    endfunction

    task automatic startRow(string name, memAddr_t base);
        rowName[rowCount] = name;
        chkBase[rowCount] = base;
        expHalt[rowCount] = 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            progMem[rowCount][i] = encodeWide(2'd1, 4'd0, 4'd0, 20'd4095);   // store to 4095
        end
        for (int i = 0; i < CHECK_WORDS; i++) begin
            expWord[rowCount][i] = fillPattern(base + memAddr_t'(i));
        end
        rowLen = 0;
        rowCount++;
    endtask

    task automatic addInsn(word_t w);
        progMem[rowCount - 1][rowLen] = w;
        rowLen++;
    endtask

    task automatic expectWord(int idx, word_t value);
        expWord[rowCount - 1][idx] = value;
    endtask

    `include "cpuPrograms.svh"

    task automatic loadWord(memAddr_t addr, word_t data);
        loadEn     = 1'b1;
        loadWe     = 1'b1;
        loadAddr   = addr;
        loadDataIn = data;
        nextCycle();
        loadEn = 1'b0;
        loadWe = 1'b0;
    endtask

    task automatic readWord(memAddr_t addr, output word_t data);
        loadEn   = 1'b1;
        loadWe   = 1'b0;
        loadAddr = addr;
        nextCycle();
        data   = loadDataOut;   // one cycle after loadEn
        loadEn = 1'b0;
    endtask

    task automatic checkWord(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic checkHalt(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic runRow(int t);
        int       cycles;
        int       errorsBefore;
        memAddr_t addr;
        word_t    got;
        errorsBefore = errors;
        reset_n      = 1'b0;
        // twelve program words and four fills make the 16 reset cycles
        for (int i = 0; i < PROG_WORDS; i++) begin
            loadWord(memAddr_t'(i), progMem[t][i]);
        end
        for (int i = 0; i < CHECK_WORDS; i++) begin
            loadWord(chkBase[t] + memAddr_t'(i), fillPattern(chkBase[t] + memAddr_t'(i)));
        end
        reset_n = 1'b1;
        checkHalt("halt_o", 1'b0, halt);
        cycles = 0;
        while (halt !== 1'b1 && cycles < RUN_TIMEOUT) begin
            nextCycle();
            cycles++;
        end
        if (halt !== 1'b1) begin
            $display("%s: no halt_o within %0d cycles", rowName[t], RUN_TIMEOUT);
            errors++;
        end
        for (int i = 0; i < CHECK_WORDS; i++) begin
            addr = chkBase[t] + memAddr_t'(i);
            readWord(addr, got);
            checkWord($sformatf("mem[%0d]", addr), expWord[t][i], got);
        end
        checkHalt("halt_o", expHalt[t], halt);   // still halted after the loader reads
        if (errors == errorsBefore) begin
            passCount++;
            $display("test %0d, %s: ok", t, rowName[t]);
        end else begin
            failCount++;
            $display("test %0d, %s: failed", t, rowName[t]);
        end
    endtask

    initial begin
        reset_n    = 1'b0;
        loadEn     = 1'b0;
        loadWe     = 1'b0;
        loadAddr   = '0;
        loadDataIn = '0;
        errors     = 0;
        passCount  = 0;
        failCount  = 0;
        buildTable();
        for (int t = 0; t < rowCount; t++) begin
            runRow(t);
        end
        $display("%0d tests, %0d passed, %0d failed", rowCount, passCount, failCount);
        if (failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+dv
src/cpuPkg.sv
src/regFile.sv
src/insnDecoder.sv
src/execUnit.sv
src/coreControl.sv
src/localMemory.sv
src/cpuTop.sv
dv/cpuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpuTb
FLAGS     ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f project.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '^>>> PASS$$'

clean:
	rm -rf obj_dir
